// File: dv/clk_gen.sv
`timescale 1ns/100ps

module clk_gen #(
	parameter real period_ns = 4.0
) (
	output logic clk_sys
);

	// free-running system clock that starts low for the first half period
	initial begin
		clk_sys = 1'b0;
	end

	always begin
		#(period_ns / 2.0);
		clk_sys = ~clk_sys;
	end

endmodule

// File: dv/tb_arcade_board.sv
`timescale 1ns/100ps
`include "arcade_defines.svh"

module tb_arcade_board;
	import arcade_pkg::*;

	localparam int n_writes  = 48;
	localparam int wd_cycles = n_writes * 16 + 2000;

	logic                    clk_sys;
	logic                    rst_n;
	ioctl_t                  ioctl;
	cfg_status_t             status;
	logic                    button_reset;
	joy_t                    joy1;
	joy_t                    joy2;
	mem_port_t               port1;
	mem_port_t               port2;
	logic                    rom_loaded;
	logic                    game_reset;
	logic                    led;
	dsw_t                    dsw;
	player_inputs_t          inputs;

	logic                    wr_prev;
	logic                    strobe;
	logic                    reset_src;
	int                      low_run;
	int                      strobe_count;
	int                      toggle_count;
	int                      error_count = 0;
	logic [`ARC_PORT_AW-1:0] exp_p1_addr;
	logic [`ARC_PORT_AW-1:0] exp_p2_addr;
	logic [1:0]              exp_p1_ds;
	logic [1:0]              exp_p2_ds;
	logic [`ARC_PORT_DW-1:0] exp_d;

	clk_gen #(.period_ns(4.0)) u_clk_gen (.clk_sys(clk_sys));

	arcade_board_top u_arcade_board_top (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.ioctl        (ioctl),
		.status       (status),
		.button_reset (button_reset),
		.joy1         (joy1),
		.joy2         (joy2),
		.port1        (port1),
		.port2        (port2),
		.rom_loaded   (rom_loaded),
		.game_reset   (game_reset),
		.led          (led),
		.dsw          (dsw),
		.inputs       (inputs)
	);

	// a byte is written on each rising wr sample while the download runs
	assign strobe    = ioctl.download && ioctl.wr && !wr_prev;
	assign reset_src = status.reset_req || button_reset || !rom_loaded;

	always_ff @(posedge clk_sys) begin
		wr_prev <= ioctl.wr;
		if (!rst_n) begin
			low_run      <= 0;
			strobe_count <= 0;
			toggle_count <= 0;
		end else begin
			// count samples since a reset source was last seen active and stop at the hold
			if (reset_src)
				low_run <= 0;
			else if (low_run < `ARC_RESET_HOLD)
				low_run <= low_run + 1;
			if (strobe)
				strobe_count <= strobe_count + 1;
			if (port1.req != $past(port1.req))
				toggle_count <= toggle_count + 1;
		end
	end

	task report_error(input string msg);
		error_count++;
		$display("Error %0t ns: %s", $time, msg);
	endtask

	function automatic dsw_t dsw_exp(input cfg_status_t s);
		dsw_t r;
		r.dsw0      = 8'hFF;
		r.dsw1      = 8'h00;
		r.dsw1[6]   = !s.difficulty;
		r.dsw1[5:4] = ~s.extend;
		r.dsw1[3:2] = ~s.lives;
		return r;
	endfunction

	function automatic player_inputs_t inputs_exp(input cfg_status_t s, input joy_t j1,
		input joy_t j2);
		player_inputs_t r;
		r.inp0    = 8'hFF;
		r.inp1    = 8'hFF;
		r.inp2    = 8'hFF;
		// a turned cabinet reads up and down in place of left and right
		r.inp0[7] = s.rotate ? !j1.up : !j1.left;
		r.inp0[6] = s.rotate ? !j1.down : !j1.right;
		r.inp0[2] = !j1.fire_a;
		r.inp1[7] = s.rotate ? !j2.up : !j2.left;
		r.inp1[6] = s.rotate ? !j2.down : !j2.right;
		r.inp1[2] = !j2.fire_a;
		r.inp2[5] = !j2.start;
		r.inp2[4] = !j1.start;
		r.inp2[0] = !j1.coin;
		return r;
	endfunction

	function automatic logic [`ARC_IOCTL_AW-1:0] random_addr();
		if ($urandom_range(1, 0) == 1)
			return `ARC_TILE_BASE + `ARC_IOCTL_AW'($urandom_range(32'h3FFFF, 0));
		else
			return `ARC_IOCTL_AW'($urandom_range(32'(`ARC_TILE_BASE) - 1, 0));
	endfunction

	toggle_on_strobe: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(port1.req != $past(port1.req)) == $past(strobe, 2)
	) else report_error("request toggle does not match a write strobe two edges earlier");

	ports_in_step: assert property (@(posedge clk_sys) disable iff (!rst_n)
		port1.req == port2.req
	) else report_error("port1 and port2 request bits differ");

	fields_mapped: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$past(strobe, 2) |-> (port1.addr == exp_p1_addr && port1.ds == exp_p1_ds &&
			port2.addr == exp_p2_addr && port2.ds == exp_p2_ds &&
			port1.d == exp_d && port2.d == exp_d)
	) else report_error("port address, lane select or data does not match the mapping");

	fields_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(port1.req == $past(port1.req)) |-> ($stable(port1.addr) && $stable(port1.ds) &&
			$stable(port1.d) && $stable(port2.addr) && $stable(port2.ds) && $stable(port2.d))
	) else report_error("port fields changed without a request toggle");

	we_follows_download: assert property (@(posedge clk_sys) disable iff (!rst_n)
		port1.we == ioctl.download && port2.we == ioctl.download && led == !ioctl.download
	) else report_error("we or led does not follow download");

	loaded_after_fall: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$fell(ioctl.download) |=> rom_loaded
	) else report_error("rom_loaded not set one cycle after download fell");

	loaded_cause: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(rom_loaded) |-> ($past(ioctl.download, 2) && !$past(ioctl.download))
	) else report_error("rom_loaded rose without a download ending");

	reset_prompt: assert property (@(posedge clk_sys) disable iff (!rst_n)
		reset_src |=> game_reset
	) else report_error("game_reset not raised one cycle after a reset source");

	reset_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(!reset_src && low_run < `ARC_RESET_HOLD) |-> game_reset
	) else report_error("game_reset fell before the hold time ran out");

	reset_released: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(!reset_src && low_run >= `ARC_RESET_HOLD) |-> !game_reset
	) else report_error("game_reset still high after the hold time");

	dsw_decode: assert property (@(posedge clk_sys)
		dsw == dsw_exp(status)
	) else report_error("dsw does not match the status encoding");

	inputs_decode: assert property (@(posedge clk_sys)
		inputs == inputs_exp(status, joy1, joy2)
	) else report_error("player inputs do not match the joystick mapping");

	task automatic write_byte(input logic [`ARC_IOCTL_AW-1:0] a, input logic [7:0] d);
		logic [`ARC_IOCTL_AW-1:0] off;
		off = a - `ARC_TILE_BASE;
		@(negedge clk_sys);
		ioctl.addr  = a;
		ioctl.dout  = d;
		exp_p1_addr = a[23:1];
		exp_p1_ds   = {a[0], !a[0]};
		exp_p2_addr = {6'd0, off[17:16], off[13:0], off[15]};
		exp_p2_ds   = {off[14], !off[14]};
		exp_d       = {d, d};
		@(negedge clk_sys);
		ioctl.wr = 1'b1;
		repeat (2) @(negedge clk_sys);
		ioctl.wr = 1'b0;
		repeat ($urandom_range(2, 1)) @(negedge clk_sys);
	endtask

	task automatic wait_game_run();
		do
			@(negedge clk_sys);
		while (game_reset);
	endtask

	task automatic pulse_reset(input logic use_button);
		@(negedge clk_sys);
		if (use_button)
			button_reset = 1'b1;
		else
			status.reset_req = 1'b1;
		repeat ($urandom_range(3, 1)) @(negedge clk_sys);
		button_reset     = 1'b0;
		status.reset_req = 1'b0;
		wait_game_run();
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic drive_inputs(input logic rot);
		@(negedge clk_sys);
		status           = cfg_status_t'(7'($urandom));
		status.reset_req = 1'b0;
		status.rotate    = rot;
		joy1             = joy_t'(8'($urandom));
		joy2             = joy_t'(8'($urandom));
	endtask

	initial begin
		void'($urandom(54));
		rst_n        = 1'b0;
		ioctl        = '0;
		status       = '0;
		button_reset = 1'b0;
		joy1         = '0;
		joy2         = '0;
		exp_p1_addr  = '0;
		exp_p2_addr  = '0;
		exp_p1_ds    = '0;
		exp_p2_ds    = '0;
		exp_d        = '0;
		repeat (5) @(negedge clk_sys);
		rst_n = 1'b1;

		// strobes before any download must not reach the ports
		repeat (4) write_byte(random_addr(), 8'($urandom));
		@(negedge clk_sys);
		ioctl.download = 1'b1;
		repeat (2) @(negedge clk_sys);
		for (int i = 0; i < n_writes; i++)
			write_byte(random_addr(), 8'($urandom));
		ioctl.download = 1'b0;
		do
			@(negedge clk_sys);
		while (!rom_loaded);
		wait_game_run();

		repeat (4) write_byte(random_addr(), 8'($urandom));
		pulse_reset(1'b0);
		pulse_reset(1'b1);
		for (int i = 0; i < 40; i++)
			drive_inputs(i[0]);
		repeat (4) @(negedge clk_sys);

		count_check: assert (strobe_count == n_writes && toggle_count == strobe_count)
		else report_error("write strobe and request toggle counts differ");

		$display("Summary: %0d errors, %0d write strobes, %0d request toggles",
			error_count, strobe_count, toggle_count);
		if (error_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	initial begin
		repeat (wd_cycles) @(posedge clk_sys);
		$display("Timeout: the run did not finish within %0d clock cycles", wd_cycles);
		$display("test failed");
		$finish;
	end

endmodule

// File: logic/arcade_board_top.sv
`timescale 1ns/100ps

module arcade_board_top (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  arcade_pkg::ioctl_t         ioctl,
	input  arcade_pkg::cfg_status_t    status,
	input  logic                       button_reset,
	input  arcade_pkg::joy_t           joy1,
	input  arcade_pkg::joy_t           joy2,
	output arcade_pkg::mem_port_t      port1,
	output arcade_pkg::mem_port_t      port2,
	output logic                       rom_loaded,
	output logic                       game_reset,
	output logic                       led,
	output arcade_pkg::dsw_t           dsw,
	output arcade_pkg::player_inputs_t inputs
);

	logic        byte_take;
	logic        loaded;
	logic        reset_src;

	// the game stays in reset until a complete image has been loaded
	assign reset_src  = status.reset_req | button_reset | ~loaded;
	assign rom_loaded = loaded;
	assign led        = ~ioctl.download;

	rom_load_ctrl u_rom_load_ctrl (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.ioctl     (ioctl),
		.byte_take (byte_take),
		.loaded    (loaded),
		.state     ()
	);

	reset_stretch u_reset_stretch (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.reset_src  (reset_src),
		.game_reset (game_reset)
	);

	rom_port_map u_rom_port_map (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.ioctl     (ioctl),
		.byte_take (byte_take),
		.port1     (port1),
		.port2     (port2)
	);

	board_inputs u_board_inputs (
		.status (status),
		.joy1   (joy1),
		.joy2   (joy2),
		.dsw    (dsw),
		.inputs (inputs)
	);

endmodule

// File: logic/arcade_defines.svh
`ifndef ARC_DEFINES_SVH
`define ARC_DEFINES_SVH

// width of the download address
`define ARC_IOCTL_AW 25

// memory port word address and data widths
`define ARC_PORT_AW 23
`define ARC_PORT_DW 16

// download address where the tile ROMs begin
`define ARC_TILE_BASE 25'h1A000

// shortest game reset in clk_sys cycles
`define ARC_RESET_HOLD 16

`endif

// File: logic/arcade_pkg.sv
`include "arcade_defines.svh"

package arcade_pkg;

	// loader progress through the ROM download
	typedef enum logic [1:0] {
		load_idle   = 2'd0,
		load_active = 2'd1,
		load_done   = 2'd2
	} load_state_t;

	// the status bits that this board actually decodes
	typedef struct packed {
		logic       reset_req;
		logic       rotate;
		logic [1:0] lives;
		logic [1:0] extend;
		logic       difficulty;
	} cfg_status_t;

	// one joystick, every bit active high
	typedef struct packed {
		logic coin;
		logic start;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	// byte-serial download stream
	typedef struct packed {
		logic                     download;
		logic                     wr;
		logic [`ARC_IOCTL_AW-1:0] addr;
		logic [7:0]               dout;
	} ioctl_t;

	// one toggle-request memory port
	// a request is any change of req and the other fields hold until the next one
	typedef struct packed {
		logic                    req;
		logic [`ARC_PORT_AW-1:0] addr;
		logic [1:0]              ds;
		logic                    we;
		logic [`ARC_PORT_DW-1:0] d;
	} mem_port_t;

	// DIP switch bytes as the game sees them, active low
	typedef struct packed {
		logic [7:0] dsw0;
		logic [7:0] dsw1;
	} dsw_t;

	// player input bytes, active low
	typedef struct packed {
		logic [7:0] inp0;
		logic [7:0] inp1;
		logic [7:0] inp2;
	} player_inputs_t;

endpackage

// File: logic/board_inputs.sv
`timescale 1ns/100ps

module board_inputs (
	input  arcade_pkg::cfg_status_t    status,
	input  arcade_pkg::joy_t           joy1,
	input  arcade_pkg::joy_t           joy2,
	output arcade_pkg::dsw_t           dsw,
	output arcade_pkg::player_inputs_t inputs
);
	import arcade_pkg::*;

	joy_t       joy1_m;
	joy_t       joy2_m;
	logic [7:0] dsw1_byte;
	logic [7:0] inp2_byte;

	// with the cabinet turned, the vertical stick axis drives left and right
	function automatic joy_t orient(input joy_t j, input logic rot);
		joy_t o;
		o = j;
		if (rot) begin
			o.left  = j.up;
			o.right = j.down;
		end
		return o;
	endfunction

	// each player byte carries the directions on top and fire A in bit 2, all active low
	function automatic logic [7:0] player_byte(input joy_t j);
		logic [7:0] raw;
		raw = {j.left, j.right, 3'b000, j.fire_a, 2'b00};
		return ~raw;
	endfunction

	assign joy1_m = orient(joy1, status.rotate);
	assign joy2_m = orient(joy2, status.rotate);

	// switch settings are inverted for the game and bit 7 is not wired
	assign dsw1_byte = {
		1'b0,
		~status.difficulty,
		~status.extend,
		~status.lives,
		2'b00
	};

	// start buttons and the coin slot share the system byte
	assign inp2_byte = ~{2'b00, joy2_m.start, joy1_m.start, 3'b000, joy1_m.coin};

	assign dsw = '{
		dsw0: 8'hFF,
		dsw1: dsw1_byte
	};

	assign inputs = '{
		inp0: player_byte(joy1_m),
		inp1: player_byte(joy2_m),
		inp2: inp2_byte
	};

endmodule

// File: logic/reset_stretch.sv
`timescale 1ns/100ps
`include "arcade_defines.svh"

module reset_stretch (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic reset_src,
	output logic game_reset
);
	localparam int cnt_w = $clog2(`ARC_RESET_HOLD + 1);

	logic [cnt_w-1:0] count;
	logic [cnt_w-1:0] count_next;

	// reload on every active sample, then run down to zero and stay there
	always_comb begin
		if (reset_src)
			count_next = cnt_w'(`ARC_RESET_HOLD);
		else if (count != '0)
			count_next = count - cnt_w'(1);
		else
			count_next = count;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			count      <= cnt_w'(`ARC_RESET_HOLD);
			game_reset <= 1'b1;
		end else begin
			count <= count_next;
			// the output follows the next count so it drops on the last tick
			game_reset <= reset_src || (count_next != '0);
		end
	end

	// every request must reach the game by the following edge
	a_reset_prompt: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		reset_src |=> game_reset
	) else $error("game_reset late after reset source at %0t", $time);

endmodule

// File: logic/rom_load_ctrl.sv
`timescale 1ns/100ps

module rom_load_ctrl (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  arcade_pkg::ioctl_t      ioctl,
	output logic                    byte_take,
	output logic                    loaded,
	output arcade_pkg::load_state_t state
);
	import arcade_pkg::*;

	load_state_t state_next;
	logic        wr_last;
	logic        dl_end;

	// the download ends on the first low sample while a transfer is running
	assign dl_end = (state == load_active) && !ioctl.download;

	always_comb begin
		state_next = state;
		case (state)
			load_idle: begin
				if (ioctl.download)
					state_next = load_active;
			end
			load_active: begin
				if (!ioctl.download)
					state_next = load_done;
			end
			load_done: begin
				// a second download rewrites the ROM but the image stays valid
				if (ioctl.download)
					state_next = load_active;
			end
			default: begin
				state_next = load_idle;
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state     <= load_idle;
			wr_last   <= 1'b0;
			byte_take <= 1'b0;
			loaded    <= 1'b0;
		end else begin
			state   <= state_next;
			wr_last <= ioctl.wr;
			// one pulse per rising write strobe while downloading
			byte_take <= ioctl.download & ioctl.wr & ~wr_last;
			if (dl_end)
				loaded <= 1'b1;
		end
	end

	// a byte can only be taken while the transfer is in progress
	a_take_only_active: assert property (
		@(posedge clk_sys) byte_take |-> (state == load_active)
	) else $error("byte_take outside load_active at %0t", $time);

	// once the image is in, only a board reset may forget it
	a_loaded_sticky: assert property (
		@(posedge clk_sys) (loaded && rst_n) |=> loaded
	) else $error("loaded fell without rst_n at %0t", $time);

endmodule

// File: logic/rom_port_map.sv
`timescale 1ns/100ps
`include "arcade_defines.svh"

module rom_port_map (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  arcade_pkg::ioctl_t    ioctl,
	input  logic                  byte_take,
	output arcade_pkg::mem_port_t port1,
	output arcade_pkg::mem_port_t port2
);
	import arcade_pkg::*;

	logic [`ARC_IOCTL_AW-1:0] tile_off;
	logic [`ARC_PORT_AW-1:0]  p1_addr_map;
	logic [`ARC_PORT_AW-1:0]  p2_addr_map;
	logic [1:0]               p1_ds_map;
	logic [1:0]               p2_ds_map;

	logic                     req1_q;
	logic                     req2_q;
	logic [`ARC_PORT_AW-1:0]  p1_addr_q;
	logic [`ARC_PORT_AW-1:0]  p2_addr_q;
	logic [1:0]               p1_ds_q;
	logic [1:0]               p2_ds_q;
	logic [`ARC_PORT_DW-1:0]  d_q;

	// program ROMs are stored as plain 16-bit words with the byte lane in addr bit 0
	assign p1_addr_map = ioctl.addr[23:1];
	assign p1_ds_map   = {ioctl.addr[0], ~ioctl.addr[0]};

	// the two tile ROMs sit 16K apart and bit 14 picks the lane so they pair up
	// into one wider word, while bit 15 moves to the bottom of the word address
	assign tile_off    = ioctl.addr - `ARC_TILE_BASE;
	assign p2_addr_map = {6'd0, tile_off[17:16], tile_off[13:0], tile_off[15]};
	assign p2_ds_map   = {tile_off[14], ~tile_off[14]};

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			req1_q    <= 1'b0;
			req2_q    <= 1'b0;
			p1_addr_q <= '0;
			p2_addr_q <= '0;
			p1_ds_q   <= 2'b00;
			p2_ds_q   <= 2'b00;
			d_q       <= '0;
		end else if (byte_take) begin
			req1_q    <= ~req1_q;
			req2_q    <= ~req2_q;
			p1_addr_q <= p1_addr_map;
			p2_addr_q <= p2_addr_map;
			p1_ds_q   <= p1_ds_map;
			p2_ds_q   <= p2_ds_map;
			d_q       <= {2{ioctl.dout}};
		end
	end

	// write enable simply follows the download
	assign port1 = '{
		req:  req1_q,
		addr: p1_addr_q,
		ds:   p1_ds_q,
		we:   ioctl.download,
		d:    d_q
	};

	assign port2 = '{
		req:  req2_q,
		addr: p2_addr_q,
		ds:   p2_ds_q,
		we:   ioctl.download,
		d:    d_q
	};

	// both ports see every byte, so their request phases never drift apart
	a_req_lockstep: assert property (
		@(posedge clk_sys) port1.req == port2.req
	) else $error("port request bits diverged at %0t", $time);

endmodule

// File: verilog.f
+incdir+logic
logic/arcade_pkg.sv
logic/rom_load_ctrl.sv
logic/reset_stretch.sv
logic/rom_port_map.sv
logic/board_inputs.sv
logic/arcade_board_top.sv
dv/clk_gen.sv
dv/tb_arcade_board.sv
